// File: common/aluPkg.sv
// ALU package
// word width and the 3-bit command encoding shared by the datapath
// and the handshake ports

package aluPkg;

  // operand and result width, fixed for this unit
  localparam int dataWidth = 32;

  // command encoding as seen on the producer side
  typedef enum logic [2:0] {
    // arithmetic group, carry and overflow meaningful
    cmdAdd  = 3'b000,
    cmdSub  = 3'b001,

    cmdXor  = 3'b010,

    // signed compare, result is 0 or 1
    cmdSlt  = 3'b011,

    // bitwise group
    cmdAnd  = 3'b100,
    cmdNand = 3'b101,
    cmdNor  = 3'b110,
    cmdOr   = 3'b111
  } aluCmd;

endpackage

// File: common/aluOperandIf.sv
// ALU operand channel
// carries one operation from the request port to the core
// with a valid/ready transfer

interface aluOperandIf;
  import aluPkg::*;

  logic [dataWidth-1:0] operandA;
  logic [dataWidth-1:0] operandB;
  aluCmd                command;
  logic                 valid;
  logic                 ready;

  // request port side
  modport src (
    output operandA, operandB, command, valid,
    input  ready
  );

  // core side
  modport dst (
    input  operandA, operandB, command, valid,
    output ready
  );

endinterface

// File: common/aluResultIf.sv
// ALU result channel
// carries one result and its flags from the core to the response port
// with a valid/ready transfer

interface aluResultIf;
  import aluPkg::*;

  logic [dataWidth-1:0] result;
  logic                 carryout;
  logic                 zero;
  logic                 overflow;
  logic                 valid;
  logic                 ready;

  // core side
  modport src (
    output result, carryout, zero, overflow, valid,
    input  ready
  );

  // response port side
  modport dst (
    input  result, carryout, zero, overflow, valid,
    output ready
  );

endinterface

// File: alu/aluBitSlice.sv
// ALU one-bit slice
// full adder with optional B inversion, plus the bitwise functions
// selected by the command

module aluBitSlice (
  input  logic          a,
  input  logic          b,
  input  logic          carryIn,
  input  aluPkg::aluCmd command,
  output logic          sum,
  output logic          carryOut
);
  import aluPkg::*;

  logic bEff;

  // subtract and compare use a + ~b + 1
  assign bEff = ((command == cmdSub) || (command == cmdSlt)) ? ~b : b;

  always_comb begin
    sum      = 1'b0;
    carryOut = carryIn;
    case (command)
      cmdAdd, cmdSub, cmdSlt: begin
        sum      = a ^ bEff ^ carryIn;
        carryOut = (a & bEff) | (carryIn & (a ^ bEff));
      end
      cmdXor: begin
        sum = a ^ b;
      end
      cmdAnd: begin
        sum = a & b;
      end
      cmdNand: begin
        sum = ~(a & b);
      end
      cmdNor: begin
        sum = ~(a | b);
      end
      cmdOr: begin
        sum = a | b;
      end
      default: begin
        sum = 1'b0;
      end
    endcase
  end

endmodule

// File: alu/aluCore.sv
// ALU core
// 32 ripple-carry slices, signed compare fix-up and flag logic,
// followed by one registered result with valid/ready on both sides

module aluCore (
  input  logic     clk,
  input  logic     rstN,
  aluOperandIf.dst opIn,
  aluResultIf.src  resOut
);
  import aluPkg::*;

  logic [dataWidth:0]   carry;
  logic [dataWidth-1:0] sliceSum;
  logic [dataWidth-1:0] resNext;
  logic                 isArith;
  logic                 ovfRaw;
  logic                 sltBit;
  logic                 accept;
  logic                 resValid;
  logic [dataWidth-1:0] resData;
  logic                 carryReg;
  logic                 zeroReg;
  logic                 ovfReg;

  assign isArith  = (opIn.command == cmdAdd) || (opIn.command == cmdSub);
  assign carry[0] = (opIn.command == cmdSub) || (opIn.command == cmdSlt);

  for (genvar i = 0; i < dataWidth; i++) begin : gSlice
    aluBitSlice aluBitSlice_i (
      .a        (opIn.operandA[i]),
      .b        (opIn.operandB[i]),
      .carryIn  (carry[i]),
      .command  (opIn.command),
      .sum      (sliceSum[i]),
      .carryOut (carry[i+1])
    );
  end

  // carry into msb vs carry out of msb
  assign ovfRaw  = carry[dataWidth] ^ carry[dataWidth-1];
  assign sltBit  = sliceSum[dataWidth-1] ^ ovfRaw;
  assign resNext = (opIn.command == cmdSlt) ? {{(dataWidth-1){1'b0}}, sltBit} : sliceSum;

  // take a new item when the register is empty or drains this cycle
  assign opIn.ready = !resValid || resOut.ready;
  assign accept     = opIn.valid && opIn.ready;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      resValid <= 1'b0;
    end else if (accept) begin
      resValid <= 1'b1;
    end else if (resOut.ready) begin
      resValid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      resData  <= resNext;
      carryReg <= isArith & carry[dataWidth];
      zeroReg  <= (resNext == '0);
      ovfReg   <= isArith & ovfRaw;
    end
  end

  assign resOut.valid    = resValid;
  assign resOut.result   = resData;
  assign resOut.carryout = carryReg;
  assign resOut.zero     = zeroReg;
  assign resOut.overflow = ovfReg;

  // held result must not move under back-pressure
  resHoldStable: assert property (@(posedge clk) disable iff (!rstN)
    resValid && !resOut.ready |=> resValid && $stable({resData, carryReg, zeroReg, ovfReg}))
    else $error("aluCore result changed while stalled");

endmodule

// File: rtl/aluReqPort.sv
// ALU request port
// four-phase receiver; captures one operation and offers it
// to the core over valid/ready

module aluReqPort (
  input  logic                         clk,
  input  logic                         rstN,
  input  logic                         inReq,
  output logic                         inAck,
  input  logic [aluPkg::dataWidth-1:0] operandA,
  input  logic [aluPkg::dataWidth-1:0] operandB,
  input  aluPkg::aluCmd                command,
  aluOperandIf.src                     opOut
);
  import aluPkg::*;

  typedef enum logic [1:0] {idle, held, waitLow} reqState;

  reqState              state;
  logic                 itemValid;
  logic [dataWidth-1:0] capA;
  logic [dataWidth-1:0] capB;
  aluCmd                capCmd;
  logic                 capture;

  assign capture = (state == idle) && inReq && !itemValid;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      state     <= idle;
      itemValid <= 1'b0;
    end else begin
      case (state)
        idle:    if (capture) state <= held;
        held:    if (!inReq) state <= waitLow;
        waitLow: state <= idle;
        default: state <= idle;
      endcase
      if (capture) begin
        itemValid <= 1'b1;
      end else if (opOut.ready) begin
        itemValid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      capA   <= operandA;
      capB   <= operandB;
      capCmd <= command;
    end
  end

  // ack stays up through held and waitLow
  assign inAck = (state != idle);

  assign opOut.valid    = itemValid;
  assign opOut.operandA = capA;
  assign opOut.operandB = capB;
  assign opOut.command  = capCmd;

  ackNeedsReq: assert property (@(posedge clk) disable iff (!rstN)
    $rose(inAck) |-> $past(inReq))
    else $error("inAck rose without inReq");

endmodule

// File: rtl/aluRespPort.sv
// ALU response port
// holds one result with its flags and presents it to the consumer
// with a four-phase req/ack sequence

module aluRespPort (
  input  logic                         clk,
  input  logic                         rstN,
  aluResultIf.dst                      resIn,
  output logic                         outReq,
  input  logic                         outAck,
  output logic [aluPkg::dataWidth-1:0] result,
  output logic                         carryout,
  output logic                         zero,
  output logic                         overflow
);
  import aluPkg::*;

  typedef enum logic [1:0] {idle, offer, waitAckLow} respState;

  respState state;
  logic     take;

  // only idle with ack low counts as empty
  assign resIn.ready = (state == idle) && !outAck;
  assign take        = resIn.valid && resIn.ready;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      state <= idle;
    end else begin
      case (state)
        idle:       if (take) state <= offer;
        offer:      if (outAck) state <= waitAckLow;
        waitAckLow: if (!outAck) state <= idle;
        default:    state <= idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      result   <= resIn.result;
      carryout <= resIn.carryout;
      zero     <= resIn.zero;
      overflow <= resIn.overflow;
    end
  end

  assign outReq = (state == offer);

  outStable: assert property (@(posedge clk) disable iff (!rstN)
    outReq && $past(outReq) |-> $stable({result, carryout, zero, overflow}))
    else $error("outputs changed while outReq high");

  reqAfterAckLow: assert property (@(posedge clk) disable iff (!rstN)
    $rose(outReq) |-> !$past(outAck))
    else $error("outReq rose while outAck high");

endmodule

// File: rtl/aluUnit.sv
// ALU unit top level
// four-phase operand input, registered ALU core and four-phase
// result output, up to three operations in flight

module aluUnit (
  input  logic                         clk,
  input  logic                         rstN,
  input  logic                         inReq,
  output logic                         inAck,
  input  logic [aluPkg::dataWidth-1:0] operandA,
  input  logic [aluPkg::dataWidth-1:0] operandB,
  input  aluPkg::aluCmd                command,
  output logic                         outReq,
  input  logic                         outAck,
  output logic [aluPkg::dataWidth-1:0] result,
  output logic                         carryout,
  output logic                         zero,
  output logic                         overflow
);

  aluOperandIf opLink ();
  aluResultIf  resLink ();

  aluReqPort aluReqPort_i (
    .clk      (clk),
    .rstN     (rstN),
    .inReq    (inReq),
    .inAck    (inAck),
    .operandA (operandA),
    .operandB (operandB),
    .command  (command),
    .opOut    (opLink.src)
  );

  aluCore aluCore_i (
    .clk    (clk),
    .rstN   (rstN),
    .opIn   (opLink.dst),
    .resOut (resLink.src)
  );

  aluRespPort aluRespPort_i (
    .clk      (clk),
    .rstN     (rstN),
    .resIn    (resLink.dst),
    .outReq   (outReq),
    .outAck   (outAck),
    .result   (result),
    .carryout (carryout),
    .zero     (zero),
    .overflow (overflow)
  );

endmodule

// File: sim/aluTb.sv
// ALU unit testbench
// drives vectors from a file through the four-phase input, acknowledges
// results with random delays and compares them in order

module aluTb;
  timeunit 1ns;
  timeprecision 1ps;
  import aluPkg::*;

  localparam int maxVectors = 64;
  localparam int fieldCount = 7;
  localparam int waitLimit  = 100;

  logic                 clk;
  logic                 rstN;
  logic                 inReq;
  logic                 inAck;
  logic [dataWidth-1:0] operandA;
  logic [dataWidth-1:0] operandB;
  aluCmd                command;
  logic                 outReq;
  logic                 outAck;
  logic [dataWidth-1:0] result;
  logic                 carryout;
  logic                 zero;
  logic                 overflow;

  // per vector: command, a, b, result, carry, zero, overflow
  logic [31:0] vecMem [maxVectors*fieldCount];
  int          vecCount;
  integer      seed;

  aluUnit aluUnit_i (
    .clk      (clk),
    .rstN     (rstN),
    .inReq    (inReq),
    .inAck    (inAck),
    .operandA (operandA),
    .operandB (operandB),
    .command  (command),
    .outReq   (outReq),
    .outAck   (outAck),
    .result   (result),
    .carryout (carryout),
    .zero     (zero),
    .overflow (overflow)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic abortRun(input string reason);
    $display("%s", reason);
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic checkValue(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
    if (actual !== expected) begin
      abortRun($sformatf("error %s: got 0x%0h, expected 0x%0h", name, actual, expected));
    end
  endtask

  task automatic waitInAck(input logic level);
    int cycles;
    cycles = 0;
    while (inAck !== level) begin
      @(negedge clk);
      cycles++;
      if (cycles > waitLimit) abortRun($sformatf("timed out waiting for inAck to be %0b", level));
    end
  endtask

  task automatic waitOutReq(input logic level);
    int cycles;
    cycles = 0;
    while (outReq !== level) begin
      @(negedge clk);
      cycles++;
      if (cycles > waitLimit) abortRun($sformatf("timed out waiting for outReq to be %0b", level));
    end
  endtask

  task automatic checkResult(input int v);
    int base;
    base = v * fieldCount;
    checkValue("result", result, vecMem[base+3]);
    checkValue("carryout", 32'(carryout), vecMem[base+4]);
    checkValue("zero", 32'(zero), vecMem[base+5]);
    checkValue("overflow", 32'(overflow), vecMem[base+6]);
  endtask

  task automatic runProducer();
    int base;
    for (int v = 0; v < vecCount; v++) begin
      base = v * fieldCount;
      @(negedge clk);
      command  = aluCmd'(vecMem[base][2:0]);
      operandA = vecMem[base+1];
      operandB = vecMem[base+2];
      inReq    = 1'b1;
      waitInAck(1'b1);
      inReq = 1'b0;
      waitInAck(1'b0);
    end
  endtask

  task automatic runConsumer();
    int delay;
    for (int v = 0; v < vecCount; v++) begin
      waitOutReq(1'b1);
      checkResult(v);
      delay = $random(seed) & 7;
      // outputs must hold while the ack is delayed
      repeat (delay) begin
        @(negedge clk);
        if (outReq !== 1'b1) abortRun("outReq dropped before outAck was raised");
        checkResult(v);
      end
      outAck = 1'b1;
      waitOutReq(1'b0);
      outAck = 1'b0;
    end
  endtask

  initial begin
    rstN         = 1'b0;
    inReq        = 1'b0;
    outAck       = 1'b0;
    operandA     = '0;
    operandB     = '0;
    command      = cmdAdd;
    seed         = 71;
    vecCount     = 0;
    // unused entries read as commands above 7
    for (int i = 0; i < maxVectors * fieldCount; i++) vecMem[i] = 32'hFFFF_0000 | 32'(i);
    $readmemh("sim/aluInput.txt", vecMem);
    while (vecCount < maxVectors && vecMem[vecCount*fieldCount] <= 32'd7) vecCount++;
    if (vecCount == 0) abortRun("no vectors were loaded from sim/aluInput.txt");

    repeat (16) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;
    repeat (3) begin
      @(negedge clk);
      checkValue("inAck", 32'(inAck), 32'h0);
      checkValue("outReq", 32'(outReq), 32'h0);
    end

    fork
      runProducer();
      runConsumer();
    join

    // no result beyond the last vector
    repeat (20) begin
      @(negedge clk);
      checkValue("outReq", 32'(outReq), 32'h0);
    end

    $display("RESULT: PASS");
    $finish;
  end

endmodule

// File: sim/aluInput.txt
// cmd operandA operandB result carryout zero overflow
// cmd: 0 add, 1 sub, 2 xor, 3 slt, 4 and, 5 nand, 6 nor, 7 or
// add
0 00000001 00000002 00000003 0 0 0
0 7FFFFFFF 00000001 80000000 0 0 1
0 FFFFFFFF 00000001 00000000 1 1 0
0 80000000 80000000 00000000 1 1 1
0 12345678 9ABCDEF0 ACF13568 0 0 0
0 FFFFFFFF FFFFFFFF FFFFFFFE 1 0 0
// sub
1 80000000 00000001 7FFFFFFF 1 0 1
1 0000000A 0000000A 00000000 1 1 0
1 00000003 00000005 FFFFFFFE 0 0 0
1 7FFFFFFF FFFFFFFF 80000000 0 0 1
1 00000000 00000000 00000000 1 1 0
1 DEADBEEF 00000001 DEADBEEE 1 0 0
// xor
2 F0F0F0F0 0FF00FF0 FF00FF00 0 0 0
2 A5A5A5A5 A5A5A5A5 00000000 0 1 0
// slt
3 00000001 00000002 00000001 0 0 0
3 00000002 00000001 00000000 0 1 0
3 FFFFFFFF 00000001 00000001 0 0 0
3 00000001 FFFFFFFF 00000000 0 1 0
3 80000000 7FFFFFFF 00000001 0 0 0
3 7FFFFFFF 80000000 00000000 0 1 0
3 00000005 00000005 00000000 0 1 0
3 FFFFFFFE FFFFFFFF 00000001 0 0 0
// and
4 FF00FF00 0FF00FF0 0F000F00 0 0 0
4 AAAAAAAA 55555555 00000000 0 1 0
// nand
5 FFFFFFFF FFFFFFFF 00000000 0 1 0
5 F0F0F0F0 FF00FF00 0FFF0FFF 0 0 0
// nor
6 00000000 00000000 FFFFFFFF 0 0 0
6 F0F0F0F0 0F0F0F0F 00000000 0 1 0
6 12340000 00005678 EDCBA987 0 0 0
// or
7 12340000 00005678 12345678 0 0 0
7 00000000 00000000 00000000 0 1 0
7 80000001 00000001 80000001 0 0 0

// File: sim.f
common/aluPkg.sv
common/aluOperandIf.sv
common/aluResultIf.sv
alu/aluBitSlice.sv
alu/aluCore.sv
rtl/aluReqPort.sv
rtl/aluRespPort.sv
rtl/aluUnit.sv
sim/aluTb.sv

// File: run.sh
#!/usr/bin/env bash
# builds the ALU testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --timescale 1ns/1ps \
  --top-module aluTb \
  -f sim.f \
  -o aluSim

./obj_dir/aluSim
